// File: design/gat_pkg.sv
`default_nettype none

package gat_pkg;

  // ========================================
  // Problem sizes
  // ========================================

  // Columns of H and rows of W
  localparam int NUM_FEATURE_IN  = 8;
  // Columns of W, one accumulator each
  localparam int NUM_FEATURE_OUT = 4;
  localparam int NUM_ROWS        = 8;
  localparam int H_DEPTH         = NUM_ROWS * NUM_FEATURE_IN;
  localparam int NUM_SUBGRAPHS   = 8;
  localparam int WH_DEPTH        = 8;
  localparam int WGT_DEPTH       = NUM_FEATURE_IN * NUM_FEATURE_OUT;

  // ========================================
  // Field widths
  // ========================================

  localparam int FEAT_W     = 8;
  // Eight 8x8 signed products fit with room to spare
  localparam int ACC_W      = 20;
  localparam int IDX_W      = $clog2(NUM_FEATURE_IN);
  // Must hold NUM_ROWS itself
  localparam int NODE_CNT_W = $clog2(NUM_ROWS + 1);
  localparam int H_ADDR_W   = $clog2(H_DEPTH);
  localparam int SG_ADDR_W  = $clog2(NUM_SUBGRAPHS);
  localparam int WH_ADDR_W  = $clog2(WH_DEPTH);
  localparam int WGT_ADDR_W = $clog2(WGT_DEPTH);

  // Sums, then node count, then source flag in bit 0
  localparam int WH_WORD_W  = NUM_FEATURE_OUT * ACC_W + NODE_CNT_W + 1;

  // ========================================
  // Types
  // ========================================

  typedef logic signed [FEAT_W-1:0]     feat_t;
  typedef logic signed [ACC_W-1:0]      acc_t;
  typedef logic        [IDX_W-1:0]      idx_t;
  typedef logic        [NODE_CNT_W-1:0] node_cnt_t;
  typedef logic        [H_ADDR_W-1:0]   h_addr_t;
  typedef logic        [SG_ADDR_W-1:0]  sg_addr_t;
  typedef logic        [WH_ADDR_W-1:0]  wh_addr_t;
  typedef logic        [WGT_ADDR_W-1:0] wgt_addr_t;
  typedef logic        [WH_WORD_W-1:0]  wh_word_t;

endpackage

`default_nettype wire

// File: design/dp_ram.sv
`timescale 1ns/1ps
`default_nettype none

// Simple dual-port memory, one write port and one read port
module dp_ram #(
  parameter  int DEPTH  = 64,
  parameter  int WIDTH  = 8,
  localparam int ADDR_W = $clog2(DEPTH)
) (
  input  logic              clk,

  // Write port
  input  logic              we,
  input  logic [ADDR_W-1:0] waddr,
  input  logic [WIDTH-1:0]  wdata,

  // Read port, data one cycle after the address
  input  logic [ADDR_W-1:0] raddr,
  output logic [WIDTH-1:0]  rdata
);

  logic [WIDTH-1:0] mem [DEPTH];

  // Write side
  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // Registered read
  // Same-address read during a write returns the old word
  always_ff @(posedge clk) begin
    rdata <= mem[raddr];
  end

endmodule

`default_nettype wire

// File: design/wgt_regs.sv
`timescale 1ns/1ps
`default_nettype none

module wgt_regs (
  input  logic                                          clk,
  input  logic                                          rst_n,

  // Byte writes, address = out column * NUM_FEATURE_IN + in row
  input  logic                                          wgt_we,
  input  gat_pkg::wgt_addr_t                            wgt_addr,
  input  gat_pkg::feat_t                                wgt_wdata,

  // Row select from the engine
  input  gat_pkg::idx_t                                 idx,
  output gat_pkg::feat_t [gat_pkg::NUM_FEATURE_OUT-1:0] wgt_row
);

  import gat_pkg::*;

  // One column of W per output feature
  feat_t [NUM_FEATURE_IN-1:0] w_col  [NUM_FEATURE_OUT];
  logic  [NUM_FEATURE_IN-1:0] wr_sel [NUM_FEATURE_OUT];

  // ========================================
  // Write decode
  // ========================================

  always_comb begin
    for (int c = 0; c < NUM_FEATURE_OUT; c++) begin
      for (int r = 0; r < NUM_FEATURE_IN; r++) begin
        wr_sel[c][r] = wgt_we && (wgt_addr == wgt_addr_t'(c * NUM_FEATURE_IN + r));
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int c = 0; c < NUM_FEATURE_OUT; c++) begin
        w_col[c] <= '0;
      end
    end else begin
      for (int c = 0; c < NUM_FEATURE_OUT; c++) begin
        for (int r = 0; r < NUM_FEATURE_IN; r++) begin
          if (wr_sel[c][r]) begin
            w_col[c][r] <= wgt_wdata;
          end
        end
      end
    end
  end

  // ========================================
  // Row read
  // ========================================

  // Same input row picked from every column
  always_comb begin
    for (int c = 0; c < NUM_FEATURE_OUT; c++) begin
      wgt_row[c] = w_col[c][idx];
    end
  end

endmodule

`default_nettype wire

// File: design/wh_engine.sv
`timescale 1ns/1ps
`default_nettype none

module wh_engine (
  input  logic                                          clk,
  input  logic                                          rst_n,
  input  logic                                          run,

  // Memory and weight read data
  input  gat_pkg::feat_t                                h_rdata,
  input  gat_pkg::node_cnt_t                            sg_rdata,
  input  gat_pkg::feat_t [gat_pkg::NUM_FEATURE_OUT-1:0] wgt_row,

  // Read addresses and weight row select
  output gat_pkg::h_addr_t                              h_raddr,
  output gat_pkg::sg_addr_t                             sg_raddr,
  output gat_pkg::idx_t                                 idx,

  // Finished rows
  output logic                                          wh_valid,
  output gat_pkg::wh_word_t                             wh_data,
  output gat_pkg::wh_addr_t                             wh_waddr
);

  import gat_pkg::*;

  // Request stage
  logic      req;
  logic      req_done;

  // Read data stage
  logic      vld_q1;
  idx_t      idx_q1;

  // Capture stage, index is the idx output
  logic      vld_q2;
  feat_t     h_q;

  // Multiply-accumulate
  acc_t [NUM_FEATURE_OUT-1:0] prod;
  acc_t [NUM_FEATURE_OUT-1:0] sum_next;
  acc_t [NUM_FEATURE_OUT-1:0] acc;
  logic      row_end;

  // Subgraph tracking
  node_cnt_t row_cnt;
  node_cnt_t sg_last;
  logic      sg_end;
  wh_word_t  word;

  // ========================================
  // Element requests
  // ========================================

  assign req = run && !req_done;

  // Address holds at the last element once everything is requested
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      h_raddr  <= '0;
      req_done <= 1'b0;
    end else if (req) begin
      if (h_raddr == h_addr_t'(H_DEPTH - 1)) begin
        req_done <= 1'b1;
      end else begin
        h_raddr <= h_raddr + 1'b1;
      end
    end
  end

  // Valid tag and column index follow the data through the RAM latency
  // Rows are NUM_FEATURE_IN aligned so the low address bits give the column
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld_q1 <= 1'b0;
      vld_q2 <= 1'b0;
      idx_q1 <= '0;
      idx    <= '0;
    end else begin
      vld_q1 <= req;
      vld_q2 <= vld_q1;
      idx_q1 <= idx_t'(h_raddr);
      idx    <= idx_q1;
    end
  end

  always_ff @(posedge clk) begin
    if (vld_q1) begin
      h_q <= h_rdata;
    end
  end

  // ========================================
  // Multiply-accumulate
  // ========================================

  // Column 0 starts a fresh sum
  always_comb begin
    for (int j = 0; j < NUM_FEATURE_OUT; j++) begin
      prod[j]     = h_q * wgt_row[j];
      sum_next[j] = (idx == '0) ? prod[j] : acc[j] + prod[j];
    end
  end

  always_ff @(posedge clk) begin
    if (vld_q2) begin
      acc <= sum_next;
    end
  end

  assign row_end = vld_q2 && (idx == idx_t'(NUM_FEATURE_IN - 1));

  // ========================================
  // Subgraph counting and result word
  // ========================================

  assign sg_last = sg_rdata - node_cnt_t'(1);
  assign sg_end  = (row_cnt == sg_last);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      row_cnt  <= '0;
      sg_raddr <= '0;
    end else if (row_end) begin
      if (sg_end) begin
        row_cnt  <= '0;
        sg_raddr <= sg_raddr + 1'b1;
      end else begin
        row_cnt <= row_cnt + 1'b1;
      end
    end
  end

  // Output sum 0 in the top bits
  always_comb begin
    word = '0;
    for (int j = 0; j < NUM_FEATURE_OUT; j++) begin
      word[WH_WORD_W-1-j*ACC_W -: ACC_W] = sum_next[j];
    end
    word[NODE_CNT_W:1] = sg_rdata;
    word[0]            = (row_cnt == '0);
  end

  always_ff @(posedge clk) begin
    if (row_end) begin
      wh_data <= word;
    end
  end

  // Result RAM address steps after each strobe
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wh_valid <= 1'b0;
      wh_waddr <= '0;
    end else begin
      wh_valid <= row_end;
      if (wh_valid) begin
        wh_waddr <= wh_waddr + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: design/wh_top.sv
`timescale 1ns/1ps
`default_nettype none

module wh_top (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                run,

  // Feature memory writes
  input  logic                h_we,
  input  gat_pkg::h_addr_t    h_waddr,
  input  gat_pkg::feat_t      h_wdata,

  // Node count writes
  input  logic                nn_we,
  input  gat_pkg::sg_addr_t   nn_waddr,
  input  gat_pkg::node_cnt_t  nn_wdata,

  // Weight writes
  input  logic                wgt_we,
  input  gat_pkg::wgt_addr_t  wgt_addr,
  input  gat_pkg::feat_t      wgt_wdata,

  // Result strobe
  output logic                wh_valid,
  output gat_pkg::wh_word_t   wh_data,

  // Result readback
  input  gat_pkg::wh_addr_t   rd_addr,
  output gat_pkg::wh_word_t   rd_data
);

  import gat_pkg::*;

  h_addr_t                    h_raddr;
  feat_t                      h_rdata;
  sg_addr_t                   sg_raddr;
  node_cnt_t                  sg_rdata;
  idx_t                       idx;
  feat_t [NUM_FEATURE_OUT-1:0] wgt_row;
  wh_addr_t                   wh_waddr;

  // ========================================
  // Memories
  // ========================================

  dp_ram #(.DEPTH(H_DEPTH), .WIDTH(FEAT_W)) feat_ram (
    .clk   (clk),
    .we    (h_we),
    .waddr (h_waddr),
    .wdata (h_wdata),
    .raddr (h_raddr),
    .rdata (h_rdata)
  );

  dp_ram #(.DEPTH(NUM_SUBGRAPHS), .WIDTH(NODE_CNT_W)) nn_ram (
    .clk   (clk),
    .we    (nn_we),
    .waddr (nn_waddr),
    .wdata (nn_wdata),
    .raddr (sg_raddr),
    .rdata (sg_rdata)
  );

  // Written by the engine strobe, read back from outside
  dp_ram #(.DEPTH(WH_DEPTH), .WIDTH(WH_WORD_W)) wh_ram (
    .clk   (clk),
    .we    (wh_valid),
    .waddr (wh_waddr),
    .wdata (wh_data),
    .raddr (rd_addr),
    .rdata (rd_data)
  );

  wgt_regs wgt_block (
    .clk       (clk),
    .rst_n     (rst_n),
    .wgt_we    (wgt_we),
    .wgt_addr  (wgt_addr),
    .wgt_wdata (wgt_wdata),
    .idx       (idx),
    .wgt_row   (wgt_row)
  );

  // ========================================
  // Engine
  // ========================================

  wh_engine engine (
    .clk      (clk),
    .rst_n    (rst_n),
    .run      (run),
    .h_rdata  (h_rdata),
    .sg_rdata (sg_rdata),
    .wgt_row  (wgt_row),
    .h_raddr  (h_raddr),
    .sg_raddr (sg_raddr),
    .idx      (idx),
    .wh_valid (wh_valid),
    .wh_data  (wh_data),
    .wh_waddr (wh_waddr)
  );

endmodule

`default_nettype wire

// File: dv/wh_props.sv
`timescale 1ns/1ps
`default_nettype none

module wh_props (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              wh_valid,
  input  logic              row_end,
  input  gat_pkg::wh_addr_t wh_waddr,
  input  gat_pkg::sg_addr_t sg_raddr
);

  import gat_pkg::*;

  // Strobe is always known out of reset
  valid_known: assert property (@(posedge clk) disable iff (!rst_n) !$isunknown(wh_valid))
    else $error("wh_valid is unknown after reset");

  // A row needs one element per cycle at best
  valid_spacing: assert property (@(posedge clk) disable iff (!rst_n)
    wh_valid |=> (!wh_valid) [*(NUM_FEATURE_IN - 1)])
    else $error("wh_valid pulses closer than one row apart");

  // Result write address moves only past a written word
  waddr_step: assert property (@(posedge clk) disable iff (!rst_n)
    (wh_waddr != $past(wh_waddr)) |-> $past(wh_valid))
    else $error("result write address changed without a result strobe");

  // Subgraph pointer moves only right after a row ends
  sg_step: assert property (@(posedge clk) disable iff (!rst_n)
    (sg_raddr != $past(sg_raddr)) |-> $past(row_end))
    else $error("sg_raddr changed outside a row end");

endmodule

bind wh_engine wh_props props (
  .clk      (clk),
  .rst_n    (rst_n),
  .wh_valid (wh_valid),
  .row_end  (row_end),
  .wh_waddr (wh_waddr),
  .sg_raddr (sg_raddr)
);

`default_nettype wire

// File: dv/wh_tb.sv
`timescale 1ns/1ps
`default_nettype none

module wh_tb;

  import gat_pkg::*;

  localparam int NUM_TESTS  = 7;
  localparam int ROW_CYCLES = NUM_ROWS * NUM_FEATURE_IN * 3;

  logic      clk;
  logic      rst_n;
  logic      run;
  logic      h_we;
  h_addr_t   h_waddr;
  feat_t     h_wdata;
  logic      nn_we;
  sg_addr_t  nn_waddr;
  node_cnt_t nn_wdata;
  logic      wgt_we;
  wgt_addr_t wgt_addr;
  feat_t     wgt_wdata;
  logic      wh_valid;
  wh_word_t  wh_data;
  wh_addr_t  rd_addr;
  wh_word_t  rd_data;

  // Copies of what the DUT memories hold
  feat_t     h_mem  [H_DEPTH];
  feat_t     w_mem  [WGT_DEPTH];
  node_cnt_t nn_mem [NUM_SUBGRAPHS];

  wh_word_t  exp_q [$];
  // Expected words of the current test in row order, kept for readback
  wh_word_t  ref_q [$];
  wh_word_t  got_q [$];
  string     test_name;
  int        errors;
  int        start_errors;
  int        passed;
  int        failed;

  wh_top uut (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ========================================
  // Reference model
  // ========================================

  function automatic wh_word_t ref_wh(input int row, input node_cnt_t num_node, input logic first);
    int s [NUM_FEATURE_OUT];
    for (int j = 0; j < NUM_FEATURE_OUT; j++) begin
      s[j] = 0;
      for (int k = 0; k < NUM_FEATURE_IN; k++) begin
        s[j] += int'(h_mem[row * NUM_FEATURE_IN + k]) * int'(w_mem[j * NUM_FEATURE_IN + k]);
      end
    end
    return {acc_t'(s[0]), acc_t'(s[1]), acc_t'(s[2]), acc_t'(s[3]), num_node, first};
  endfunction

  // Walk the subgraphs to get each row's count and source flag
  task automatic build_expected();
    int       row;
    wh_word_t word;
    row = 0;
    exp_q.delete();
    ref_q.delete();
    for (int sg = 0; sg < NUM_SUBGRAPHS && row < NUM_ROWS; sg++) begin
      for (int n = 0; n < int'(nn_mem[sg]) && row < NUM_ROWS; n++) begin
        word = ref_wh(row, nn_mem[sg], n == 0);
        exp_q.push_back(word);
        ref_q.push_back(word);
        row++;
      end
    end
  endtask

  task automatic set_counts(input int a, input int b, input int c);
    foreach (nn_mem[i]) nn_mem[i] = node_cnt_t'(1);
    nn_mem[0] = node_cnt_t'(a);
    nn_mem[1] = node_cnt_t'(b);
    nn_mem[2] = node_cnt_t'(c);
  endtask

  task automatic fill_random();
    foreach (h_mem[i]) h_mem[i] = feat_t'($urandom);
    foreach (w_mem[i]) w_mem[i] = feat_t'($urandom);
  endtask

  // ========================================
  // Comparator
  // ========================================

  initial begin
    wh_word_t exp;
    forever begin
      @(negedge clk);
      if (wh_valid === 1'b1) begin
        got_q.push_back(wh_data);
        if (exp_q.size() == 0) begin
          $display("test %s: a result word arrived when none was expected", test_name);
          errors++;
        end else begin
          exp = exp_q.pop_front();
          assert (wh_data === exp)
            else begin
              $display("Error: %s expected %h actual %h", test_name, exp, wh_data);
              errors++;
            end
        end
      end
    end
  end

  // ========================================
  // Test steps
  // ========================================

  // Reset, then load H, weights and counts through all three ports at once
  task automatic start_test(input string name);
    test_name    = name;
    start_errors = errors;
    got_q.delete();
    run   = 1'b0;
    rst_n = 1'b0;
    repeat (4) begin
      @(negedge clk);
      assert (wh_valid === 1'b0)
        else begin
          $display("test %s: wh_valid was not low during reset", test_name);
          errors++;
        end
    end
    @(posedge clk);
    #2;
    rst_n = 1'b1;
    build_expected();
    for (int i = 0; i < H_DEPTH; i++) begin
      h_we      = 1'b1;
      h_waddr   = h_addr_t'(i);
      h_wdata   = h_mem[i];
      wgt_we    = (i < WGT_DEPTH);
      wgt_addr  = wgt_addr_t'(i);
      wgt_wdata = w_mem[i % WGT_DEPTH];
      nn_we     = (i < NUM_SUBGRAPHS);
      nn_waddr  = sg_addr_t'(i);
      nn_wdata  = nn_mem[i % NUM_SUBGRAPHS];
      @(posedge clk);
      #2;
    end
    h_we   = 1'b0;
    wgt_we = 1'b0;
    nn_we  = 1'b0;
  endtask

  // Run until every row is seen, optionally toggling run in spans
  task automatic stream_rows(input logic paused);
    int span;
    span = 0;
    run  = 1'b1;
    for (int c = 0; c < ROW_CYCLES && got_q.size() < NUM_ROWS; c++) begin
      if (paused && span == 0) begin
        run  = ~run;
        span = 1 + $urandom_range(4, 0);
      end
      span--;
      @(posedge clk);
      #2;
    end
    assert (got_q.size() == NUM_ROWS)
      else begin
        $display("test %s: results were missing, %0d of %0d words arrived",
                 test_name, got_q.size(), NUM_ROWS);
        errors++;
      end
  endtask

  task automatic check_readback();
    for (int a = 0; a < WH_DEPTH; a++) begin
      rd_addr = wh_addr_t'(a);
      @(negedge clk);
      @(negedge clk);
      assert (rd_data === ref_q[a])
        else begin
          $display("Error: %s readback %0d expected %h actual %h",
                   test_name, a, ref_q[a], rd_data);
          errors++;
        end
      @(posedge clk);
      #2;
    end
  endtask

  task automatic end_test();
    if (errors == start_errors) begin
      passed++;
      $display("test %s: ok", test_name);
    end else begin
      failed++;
      $display("test %s: %0d errors", test_name, errors - start_errors);
    end
  endtask

  // ========================================
  // Main sequence
  // ========================================

  initial begin
    int unsigned seed;
    seed      = $urandom(38);
    rst_n     = 1'b0;
    run       = 1'b0;
    h_we      = 1'b0;
    h_waddr   = '0;
    h_wdata   = '0;
    nn_we     = 1'b0;
    nn_waddr  = '0;
    nn_wdata  = '0;
    wgt_we    = 1'b0;
    wgt_addr  = '0;
    wgt_wdata = '0;
    rd_addr   = '0;
    errors    = 0;
    passed    = 0;
    failed    = 0;

    fill_random();
    set_counts(8, 1, 1);
    start_test("basic");
    stream_rows(1'b0);
    end_test();

    fill_random();
    set_counts(3, 2, 3);
    start_test("grouping");
    stream_rows(1'b0);
    end_test();

    // Same data as grouping, so the words must not change
    start_test("pausing");
    stream_rows(1'b1);
    end_test();

    foreach (h_mem[i]) h_mem[i] = -8'sd128;
    foreach (w_mem[i]) w_mem[i] = -8'sd128;
    set_counts(8, 1, 1);
    start_test("extreme_neg");
    stream_rows(1'b0);
    end_test();

    foreach (h_mem[i]) h_mem[i] = (i % 2 == 0) ? -8'sd128 : 8'sd127;
    foreach (w_mem[i]) w_mem[i] = (i % 3 == 0) ? 8'sd127 : -8'sd128;
    start_test("mixed_signs");
    stream_rows(1'b0);
    end_test();

    fill_random();
    set_counts(2, 4, 2);
    start_test("readback");
    stream_rows(1'b0);
    check_readback();
    end_test();

    fill_random();
    set_counts(8, 1, 1);
    start_test("reset_idle");
    repeat (16) @(posedge clk);
    #2;
    assert (got_q.size() == 0)
      else begin
        $display("test %s: a result appeared while run was low", test_name);
        errors++;
      end
    stream_rows(1'b0);
    end_test();

    $display("tests %0d, passed %0d, failed %0d, errors %0d", NUM_TESTS, passed, failed, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(NUM_TESTS * ROW_CYCLES * 40 + 2000);
    $display("watchdog: the run did not finish in time");
    $display(">>> FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: wh_top.f
design/gat_pkg.sv
design/dp_ram.sv
design/wgt_regs.sv
design/wh_engine.sv
design/wh_top.sv
dv/wh_props.sv
dv/wh_tb.sv

// File: Bender.yml
package:
  name: wh_top

sources:
  - files:
      - design/gat_pkg.sv
      - design/dp_ram.sv
      - design/wgt_regs.sv
      - design/wh_engine.sv
      - design/wh_top.sv
  - target: test
    files:
      - dv/wh_props.sv
      - dv/wh_tb.sv
